/* src/axil_demux_defines.svh */
// ----------------------------------------------------------------------
// AXI4-Lite demultiplexer parameters
// bus widths, target port count and outstanding transaction depth
// ----------------------------------------------------------------------

`ifndef AXIL_DEMUX_DEFINES_SVH
`define AXIL_DEMUX_DEFINES_SVH

// bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// routing, at least two target ports
`define DEMUX_NUM_PORTS 4
`define DEMUX_SEL_WIDTH 2

// default depth of each select FIFO
`define DEMUX_MAX_TRANS 4

`endif

/* src/axil_pkg.sv */
// ----------------------------------------------------------------------
// AXI4-Lite bus types
// channel payloads, response code and request/response bundles
// ----------------------------------------------------------------------

`include "axil_demux_defines.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  // ----------------------------------------------------------------------
  // manager to target and target to manager bundles
  // ----------------------------------------------------------------------
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axil_rsp_t;

endpackage

/* src/demux_pkg.sv */
// ----------------------------------------------------------------------
// demultiplexer routing types
// target port index and AW lock state
// ----------------------------------------------------------------------

`include "axil_demux_defines.svh"

package demux_pkg;

  // index of one downstream target port
  typedef logic [`DEMUX_SEL_WIDTH-1:0] port_sel_t;

  // AW_LOCKED holds a request whose select already sits in the W FIFO
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

/* src/select_fifo.sv */
// ----------------------------------------------------------------------
// select FIFO
// keeps the target port of every outstanding transaction in order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module select_fifo #(
  parameter int unsigned DEPTH = `DEMUX_MAX_TRANS
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  demux_pkg::port_sel_t sel_i,
  input  logic                 pop_i,
  output demux_pkg::port_sel_t sel_o,
  output logic                 full_o,
  output logic                 empty_o
);

  import demux_pkg::*;

  localparam int unsigned PTR_WIDTH = $clog2(DEPTH);
  localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  port_sel_t            mem [DEPTH];
  ptr_t                 rd_ptr_q;
  ptr_t                 wr_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic                 do_push;
  logic                 do_pop;

  // wrap explicitly so depths other than powers of two work
  function automatic ptr_t next_ptr(ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
  assign empty_o = (count_q == '0);
  assign sel_o   = mem[rd_ptr_q];

  // a full FIFO still takes a push when the head leaves in the same cycle
  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full_o | do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* src/write_path.sv */
// ----------------------------------------------------------------------
// demultiplexer write path
// routes AW by its select, steers W by the W FIFO head and returns
// B responses in request order through the B FIFO
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module write_path (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  axil_pkg::axil_req_t                          slv_req_i,
  input  demux_pkg::port_sel_t                         aw_sel_i,
  output axil_pkg::axil_rsp_t                          slv_rsp_o,
  output axil_pkg::axil_req_t [`DEMUX_NUM_PORTS-1:0] mst_reqs_o,
  input  axil_pkg::axil_rsp_t [`DEMUX_NUM_PORTS-1:0] mst_rsps_i
);

  import axil_pkg::*;
  import demux_pkg::*;

  aw_state_e                   aw_state_q;
  aw_state_e                   aw_state_d;
  logic [`DEMUX_NUM_PORTS-1:0] aw_valids;
  logic                        aw_ready;
  logic                        w_fifo_push;
  logic                        w_fifo_full;
  logic                        w_fifo_empty;
  port_sel_t                   w_sel;
  logic                        w_open;
  logic                        w_ready;
  logic                        w_fifo_pop;
  logic                        b_fifo_full;
  logic                        b_fifo_empty;
  port_sel_t                   b_sel;
  logic                        b_valid;
  logic                        b_fifo_pop;

  // ----------------------------------------------------------------------
  // AW channel
  // ----------------------------------------------------------------------
  always_comb begin
    aw_state_d  = aw_state_q;
    aw_valids   = '0;
    aw_ready    = 1'b0;
    w_fifo_push = 1'b0;
    if (aw_state_q == AW_LOCKED) begin
      // select was pushed already, only wait for the target
      aw_valids[aw_sel_i] = 1'b1;
      if (mst_rsps_i[aw_sel_i].aw_ready) begin
        aw_ready   = 1'b1;
        aw_state_d = AW_IDLE;
      end
    end else if (slv_req_i.aw_valid && !w_fifo_full) begin
      w_fifo_push         = 1'b1;
      aw_valids[aw_sel_i] = 1'b1;
      if (mst_rsps_i[aw_sel_i].aw_ready) begin
        aw_ready = 1'b1;
      end else begin
        aw_state_d = AW_LOCKED;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_state_q <= AW_IDLE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  select_fifo #(
    .DEPTH   (`DEMUX_MAX_TRANS)
  ) i_w_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_fifo_push),
    .sel_i   (aw_sel_i),
    .pop_i   (w_fifo_pop),
    .sel_o   (w_sel),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // ----------------------------------------------------------------------
  // W channel
  // ----------------------------------------------------------------------
  // room is needed in the B FIFO before a beat may leave
  assign w_open     = ~w_fifo_empty & ~b_fifo_full;
  assign w_ready    = w_open & mst_rsps_i[w_sel].w_ready;
  assign w_fifo_pop = slv_req_i.w_valid & w_ready;

  // the W FIFO head moves on to the B FIFO with the beat
  select_fifo #(
    .DEPTH   (`DEMUX_MAX_TRANS)
  ) i_b_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_fifo_pop),
    .sel_i   (w_sel),
    .pop_i   (b_fifo_pop),
    .sel_o   (b_sel),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // ----------------------------------------------------------------------
  // B channel and port outputs
  // ----------------------------------------------------------------------
  assign b_valid    = ~b_fifo_empty & mst_rsps_i[b_sel].b_valid;
  assign b_fifo_pop = b_valid & slv_req_i.b_ready;

  // read channel fields belong to the read path and stay zero here
  always_comb begin
    mst_reqs_o = '0;
    for (int unsigned i = 0; i < `DEMUX_NUM_PORTS; i++) begin
      mst_reqs_o[i].aw       = slv_req_i.aw;
      mst_reqs_o[i].aw_valid = aw_valids[i];
      mst_reqs_o[i].w        = slv_req_i.w;
      mst_reqs_o[i].w_valid  = w_open & slv_req_i.w_valid & (w_sel == port_sel_t'(i));
      mst_reqs_o[i].b_ready  = ~b_fifo_empty & slv_req_i.b_ready & (b_sel == port_sel_t'(i));
    end
  end

  always_comb begin
    slv_rsp_o          = '0;
    slv_rsp_o.aw_ready = aw_ready;
    slv_rsp_o.w_ready  = w_ready;
    slv_rsp_o.b_valid  = b_valid;
    if (!b_fifo_empty) begin
      slv_rsp_o.b = mst_rsps_i[b_sel].b;
    end
  end

endmodule

/* src/read_path.sv */
// ----------------------------------------------------------------------
// demultiplexer read path
// routes AR by its select and returns R data in request order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module read_path (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  axil_pkg::axil_req_t                          slv_req_i,
  input  demux_pkg::port_sel_t                         ar_sel_i,
  output axil_pkg::axil_rsp_t                          slv_rsp_o,
  output axil_pkg::axil_req_t [`DEMUX_NUM_PORTS-1:0] mst_reqs_o,
  input  axil_pkg::axil_rsp_t [`DEMUX_NUM_PORTS-1:0] mst_rsps_i
);

  import axil_pkg::*;
  import demux_pkg::*;

  logic      ar_open;
  logic      ar_ready;
  logic      r_fifo_push;
  logic      r_fifo_pop;
  logic      r_fifo_full;
  logic      r_fifo_empty;
  port_sel_t r_sel;
  logic      r_valid;
  r_chan_t   r_chan;

  // ----------------------------------------------------------------------
  // AR channel
  // ----------------------------------------------------------------------
  // no request goes out without a free slot to remember its target
  assign ar_open     = ~r_fifo_full;
  assign ar_ready    = ar_open & mst_rsps_i[ar_sel_i].ar_ready;
  assign r_fifo_push = slv_req_i.ar_valid & ar_ready;

  select_fifo #(
    .DEPTH   (`DEMUX_MAX_TRANS)
  ) i_r_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (r_fifo_push),
    .sel_i   (ar_sel_i),
    .pop_i   (r_fifo_pop),
    .sel_o   (r_sel),
    .full_o  (r_fifo_full),
    .empty_o (r_fifo_empty)
  );

  // ----------------------------------------------------------------------
  // R channel
  // ----------------------------------------------------------------------
  // only the oldest outstanding target may answer
  assign r_valid    = ~r_fifo_empty & mst_rsps_i[r_sel].r_valid;
  assign r_chan     = r_fifo_empty ? r_chan_t'('0) : mst_rsps_i[r_sel].r;
  assign r_fifo_pop = r_valid & slv_req_i.r_ready;

  // write channel fields belong to the write path and stay zero here
  always_comb begin
    mst_reqs_o = '0;
    for (int unsigned i = 0; i < `DEMUX_NUM_PORTS; i++) begin
      mst_reqs_o[i].ar       = slv_req_i.ar;
      mst_reqs_o[i].ar_valid = ar_open & slv_req_i.ar_valid & (ar_sel_i == port_sel_t'(i));
      mst_reqs_o[i].r_ready  = ~r_fifo_empty & slv_req_i.r_ready & (r_sel == port_sel_t'(i));
    end
  end

  always_comb begin
    slv_rsp_o          = '0;
    slv_rsp_o.ar_ready = ar_ready;
    slv_rsp_o.r        = r_chan;
    slv_rsp_o.r_valid  = r_valid;
  end

endmodule

/* src/axil_demux_top.sv */
// ----------------------------------------------------------------------
// AXI4-Lite demultiplexer
// fans one manager port out to several targets, one write path and
// one read path
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module axil_demux_top (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  axil_pkg::axil_req_t                          slv_req_i,
  input  demux_pkg::port_sel_t                         aw_sel_i,
  input  demux_pkg::port_sel_t                         ar_sel_i,
  output axil_pkg::axil_rsp_t                          slv_rsp_o,
  output axil_pkg::axil_req_t [`DEMUX_NUM_PORTS-1:0] mst_reqs_o,
  input  axil_pkg::axil_rsp_t [`DEMUX_NUM_PORTS-1:0] mst_rsps_i
);

  import axil_pkg::*;

  axil_rsp_t                         wr_rsp;
  axil_rsp_t                         rd_rsp;
  axil_req_t [`DEMUX_NUM_PORTS-1:0] wr_reqs;
  axil_req_t [`DEMUX_NUM_PORTS-1:0] rd_reqs;

  write_path i_write_path (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req_i),
    .aw_sel_i   (aw_sel_i),
    .slv_rsp_o  (wr_rsp),
    .mst_reqs_o (wr_reqs),
    .mst_rsps_i (mst_rsps_i)
  );

  read_path i_read_path (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req_i),
    .ar_sel_i   (ar_sel_i),
    .slv_rsp_o  (rd_rsp),
    .mst_reqs_o (rd_reqs),
    .mst_rsps_i (mst_rsps_i)
  );

  // ----------------------------------------------------------------------
  // merge the disjoint write and read fields
  // ----------------------------------------------------------------------
  assign slv_rsp_o = '{
    aw_ready: wr_rsp.aw_ready,
    w_ready:  wr_rsp.w_ready,
    b:        wr_rsp.b,
    b_valid:  wr_rsp.b_valid,
    ar_ready: rd_rsp.ar_ready,
    r:        rd_rsp.r,
    r_valid:  rd_rsp.r_valid
  };

  for (genvar i = 0; i < `DEMUX_NUM_PORTS; i++) begin : gen_mst_req
    assign mst_reqs_o[i] = '{
      aw:       wr_reqs[i].aw,
      aw_valid: wr_reqs[i].aw_valid,
      w:        wr_reqs[i].w,
      w_valid:  wr_reqs[i].w_valid,
      b_ready:  wr_reqs[i].b_ready,
      ar:       rd_reqs[i].ar,
      ar_valid: rd_reqs[i].ar_valid,
      r_ready:  rd_reqs[i].r_ready
    };
  end

endmodule

/* sim/target_model.sv */
// ----------------------------------------------------------------------
// behavioral AXI4-Lite target
// 16 word memory, random ready and response delays, always OKAY
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module target_model (
  input  logic                clk_i,
  input  logic                reset_i,
  input  axil_pkg::axil_req_t req_i,
  output axil_pkg::axil_rsp_t rsp_o
);

  import axil_pkg::*;

  data_t      mem [16];
  logic [3:0] wr_idx;
  logic       aw_held;
  logic       b_pend;
  logic       r_pend;
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] b_wait;
  logic [1:0] ar_wait;
  logic [1:0] r_wait;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_o   <= '0;
      wr_idx  <= '0;
      aw_held <= 1'b0;
      b_pend  <= 1'b0;
      r_pend  <= 1'b0;
      aw_wait <= '0;
      w_wait  <= '0;
      b_wait  <= '0;
      ar_wait <= '0;
      r_wait  <= '0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // one write address held until its data arrives
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        rsp_o.aw_ready <= 1'b0;
        aw_held        <= 1'b1;
        wr_idx         <= req_i.aw.addr[5:2];
        aw_wait        <= 2'($urandom % 4);
      end else if (req_i.aw_valid && !aw_held) begin
        if (aw_wait == 0) rsp_o.aw_ready <= 1'b1;
        else aw_wait <= aw_wait - 1'b1;
      end
      if (req_i.w_valid && rsp_o.w_ready) begin
        for (int b = 0; b < `AXIL_DATA_WIDTH / 8; b++) begin
          if (req_i.w.strb[b]) mem[wr_idx][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
        rsp_o.w_ready <= 1'b0;
        aw_held       <= 1'b0;
        b_pend        <= 1'b1;
        w_wait        <= 2'($urandom % 4);
        b_wait        <= 2'($urandom % 4);
      end else if (req_i.w_valid && aw_held && !b_pend) begin
        if (w_wait == 0) rsp_o.w_ready <= 1'b1;
        else w_wait <= w_wait - 1'b1;
      end
      if (rsp_o.b_valid && req_i.b_ready) begin
        rsp_o.b_valid <= 1'b0;
        b_pend        <= 1'b0;
      end else if (b_pend && !rsp_o.b_valid) begin
        if (b_wait == 0) begin
          rsp_o.b_valid <= 1'b1;
          rsp_o.b.resp  <= RESP_OKAY;
        end else begin
          b_wait <= b_wait - 1'b1;
        end
      end
      // read data is taken from memory at the address handshake
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        rsp_o.ar_ready <= 1'b0;
        r_pend         <= 1'b1;
        rsp_o.r.data   <= mem[req_i.ar.addr[5:2]];
        rsp_o.r.resp   <= RESP_OKAY;
        ar_wait        <= 2'($urandom % 4);
      end else if (req_i.ar_valid && !r_pend) begin
        if (ar_wait == 0) rsp_o.ar_ready <= 1'b1;
        else ar_wait <= ar_wait - 1'b1;
      end
      if (rsp_o.r_valid && req_i.r_ready) begin
        rsp_o.r_valid <= 1'b0;
        r_pend        <= 1'b0;
        r_wait        <= 2'($urandom % 4);
      end else if (r_pend && !rsp_o.r_valid) begin
        if (r_wait == 0) rsp_o.r_valid <= 1'b1;
        else r_wait <= r_wait - 1'b1;
      end
    end
  end

endmodule

/* sim/tb_axil_demux.sv */
// ----------------------------------------------------------------------
// testbench for the AXI4-Lite demultiplexer
// replays the test vectors on the manager port with one target model
// on each port and checks every response against a scoreboard
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "axil_demux_defines.svh"

module tb_axil_demux;

  import axil_pkg::*;
  import demux_pkg::*;

  typedef struct packed {
    logic      is_write;
    port_sel_t port;
    addr_t     addr;
    data_t     data;
    logic      stall;
  } vector_t;

  logic                             clk_i = 1'b0;
  logic                             reset_i = 1'b1;
  axil_req_t                        drv_req = '0;
  logic                             b_ready = 1'b0;
  logic                             r_ready = 1'b0;
  port_sel_t                        aw_sel = '0;
  port_sel_t                        ar_sel = '0;
  axil_req_t                        slv_req;
  axil_rsp_t                        slv_rsp;
  axil_req_t [`DEMUX_NUM_PORTS-1:0] mst_reqs;
  axil_rsp_t [`DEMUX_NUM_PORTS-1:0] mst_rsps;

  vector_t     vectors [$];
  data_t       exp_mem [`DEMUX_NUM_PORTS][16];
  data_t       exp_rdata [$];
  int unsigned b_pending = 0;
  int unsigned errors = 0;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 100000;
  logic        stall_mode = 1'b0;

  always #20 clk_i = ~clk_i;

  always_comb begin
    slv_req         = drv_req;
    slv_req.b_ready = b_ready;
    slv_req.r_ready = r_ready;
  end

  axil_demux_top UUT (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req),
    .aw_sel_i   (aw_sel),
    .ar_sel_i   (ar_sel),
    .slv_rsp_o  (slv_rsp),
    .mst_reqs_o (mst_reqs),
    .mst_rsps_i (mst_rsps)
  );

  for (genvar i = 0; i < `DEMUX_NUM_PORTS; i++) begin : gen_target
    target_model i_target (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (mst_reqs[i]),
      .rsp_o   (mst_rsps[i])
    );
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] seen);
    errors++;
    $display("error at %0t ns: %s expected %h got %h", $time, name, expected, seen);
  endtask

  // inputs change 2 ns after the rising edge
  task automatic wait_drive_point();
    @(posedge clk_i);
    #2;
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] port;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] stall;
    vector_t     v;
    fd = $fopen("sim/demux_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test data file sim/demux_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h", op, port, addr, data, stall);
          if (n == 5 && (op == "W" || op == "R")) begin
            v.is_write = (op == "W");
            v.port     = port_sel_t'(port);
            v.addr     = addr;
            v.data     = data;
            v.stall    = stall[0];
            vectors.push_back(v);
          end else if (n > 0) begin
            errors++;
            $display("test data line cannot be read: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle();
    if (slv_rsp.b_valid !== 1'b0) report_mismatch("b_valid", 0, slv_rsp.b_valid);
    if (slv_rsp.r_valid !== 1'b0) report_mismatch("r_valid", 0, slv_rsp.r_valid);
    for (int i = 0; i < `DEMUX_NUM_PORTS; i++) begin
      if (mst_reqs[i].aw_valid !== 1'b0)
        report_mismatch($sformatf("mst_reqs[%0d].aw_valid", i), 0, mst_reqs[i].aw_valid);
      if (mst_reqs[i].w_valid !== 1'b0)
        report_mismatch($sformatf("mst_reqs[%0d].w_valid", i), 0, mst_reqs[i].w_valid);
      if (mst_reqs[i].ar_valid !== 1'b0)
        report_mismatch($sformatf("mst_reqs[%0d].ar_valid", i), 0, mst_reqs[i].ar_valid);
    end
  endtask

  // writes wait for earlier reads, then pipeline behind each other
  task automatic do_write(input vector_t v);
    logic aw_hit;
    logic w_hit;
    while (exp_rdata.size() != 0) wait_drive_point();
    aw_sel           = v.port;
    drv_req.aw       = '{addr: v.addr, prot: 3'b000};
    drv_req.aw_valid = 1'b1;
    drv_req.w        = '{data: v.data, strb: '1};
    drv_req.w_valid  = 1'b1;
    b_pending++;
    exp_mem[v.port][v.addr[5:2]] = v.data;
    while (drv_req.aw_valid || drv_req.w_valid) begin
      @(negedge clk_i);
      aw_hit = drv_req.aw_valid & slv_rsp.aw_ready;
      w_hit  = drv_req.w_valid & slv_rsp.w_ready;
      wait_drive_point();
      if (aw_hit) drv_req.aw_valid = 1'b0;
      if (w_hit) drv_req.w_valid = 1'b0;
    end
  endtask

  // reads wait for all write responses, then issue without waiting for R
  task automatic do_read(input vector_t v, input int idx);
    data_t expected;
    logic  ar_hit;
    while (b_pending != 0) wait_drive_point();
    expected = exp_mem[v.port][v.addr[5:2]];
    if (expected !== v.data) begin
      errors++;
      $display("test vector %0d expects %h but the scoreboard holds %h", idx, v.data, expected);
    end
    ar_sel           = v.port;
    drv_req.ar       = '{addr: v.addr, prot: 3'b000};
    drv_req.ar_valid = 1'b1;
    ar_hit           = 1'b0;
    while (!ar_hit) begin
      @(negedge clk_i);
      ar_hit = slv_rsp.ar_ready;
      if (ar_hit) exp_rdata.push_back(expected);
      wait_drive_point();
    end
    drv_req.ar_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // response checking and manager ready
  // ----------------------------------------------------------------------
  initial begin
    data_t expected;
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      if (slv_rsp.b_valid && slv_req.b_ready) begin
        if (b_pending == 0) begin
          errors++;
          $display("B response at %0t ns with no write outstanding", $time);
        end else begin
          b_pending--;
          if (slv_rsp.b.resp !== RESP_OKAY)
            report_mismatch("b.resp", 32'(RESP_OKAY), 32'(slv_rsp.b.resp));
        end
      end
      if (slv_rsp.r_valid && slv_req.r_ready) begin
        if (exp_rdata.size() == 0) begin
          errors++;
          $display("R response at %0t ns with no read outstanding", $time);
        end else begin
          expected = exp_rdata.pop_front();
          if (slv_rsp.r.data !== expected) report_mismatch("r.data", expected, slv_rsp.r.data);
          if (slv_rsp.r.resp !== RESP_OKAY)
            report_mismatch("r.resp", 32'(RESP_OKAY), 32'(slv_rsp.r.resp));
        end
      end
      wait_drive_point();
      b_ready = stall_mode ? ($urandom % 3 == 0) : 1'b1;
      r_ready = stall_mode ? ($urandom % 3 == 0) : 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: test did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(21));
    // every target memory starts at zero
    for (int p = 0; p < `DEMUX_NUM_PORTS; p++) begin
      for (int w = 0; w < 16; w++) begin
        exp_mem[p][w] = '0;
      end
    end
    load_vectors();
    cycle_limit = 40 * vectors.size() + 200;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle();
    wait_drive_point();
    foreach (vectors[i]) begin
      stall_mode = vectors[i].stall;
      if (vectors[i].is_write) do_write(vectors[i]);
      else do_read(vectors[i], i);
    end
    stall_mode = 1'b0;
    while (b_pending != 0 || exp_rdata.size() != 0) wait_drive_point();
    // idle cycles catch any extra response
    repeat (10) wait_drive_point();
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+src
src/axil_pkg.sv
src/demux_pkg.sv
src/select_fifo.sv
src/write_path.sv
src/read_path.sv
src/axil_demux_top.sv
sim/target_model.sv
sim/tb_axil_demux.sv

/* Bender.yml */
package:
  name: axil_demux

export_include_dirs:
  - src

sources:
  - src/axil_pkg.sv
  - src/demux_pkg.sv
  - src/select_fifo.sv
  - src/write_path.sv
  - src/read_path.sv
  - src/axil_demux_top.sv
  - target: simulation
    files:
      - sim/target_model.sv
      - sim/tb_axil_demux.sv

/* sim/demux_testdata.txt */
# op port addr data stall: op is W or R, port 0 to 3, addr and data in hex
# R data is the expected value, stall 1 lets b_ready and r_ready drop at random
W 1 00000008 a5a5a5a5 0
R 1 00000008 a5a5a5a5 0
W 0 00000010 00000100 0
W 1 00000010 00000101 0
W 2 00000010 00000102 0
W 3 00000010 00000103 0
R 0 00000010 00000100 0
R 1 00000010 00000101 0
R 2 00000010 00000102 0
R 3 00000010 00000103 0
R 0 00000008 00000000 0
R 1 00000008 a5a5a5a5 0
R 2 00000008 00000000 0
R 1 00000010 00000101 0
R 0 00000010 00000100 0
R 3 00000010 00000103 0
W 2 00000020 20202020 1
W 3 00000024 30303030 1
W 2 00000028 21212121 1
W 3 0000002c 31313131 1
W 2 0000003c 22222222 1
W 3 00000000 32323232 1
R 2 00000020 20202020 1
R 3 00000024 30303030 1
R 2 00000028 21212121 1
R 3 0000002c 31313131 1
R 2 0000003c 22222222 1
R 3 00000000 32323232 1
R 2 00000010 00000102 1
